/* design/axi_rd_pkg.sv */
/*
 * Shared widths, depths and types for the two-client AXI read subsystem.
 * Imported by the channel interface and every RTL block of the design.
 */
package axi_rd_pkg;

    // Sizes
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int MEM_WORDS  = 256;
    localparam int MEM_AW     = $clog2(MEM_WORDS);
    localparam int NUM_PORTS  = 2;
    localparam int PORT_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    // Channel fields
    typedef logic [31:0] data_t;
    typedef logic [15:0] addr_t;
    typedef logic [3:0]  id_t;
    typedef logic [7:0]  len_t;

    // Word index into the memory, taken from address bits above the byte lane
    typedef logic [MEM_AW-1:0] mem_idx_t;

    // FIFO pointer with one wrap bit
    typedef logic [FIFO_AW:0] fifo_ptr_t;

    // Beat count, wide enough for a full buffer plus the longest burst
    typedef logic [9:0] fifo_cnt_t;

    typedef logic [PORT_W-1:0] port_t;

    // Stored R beat, packed as {rid, rlast, rdata}
    localparam int R_ENTRY_W = $bits(id_t) + 1 + $bits(data_t);
    typedef logic [R_ENTRY_W-1:0] r_entry_t;

    typedef enum logic {
        AR_IDLE,
        AR_WAIT
    } fifo_ar_state_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_BURST
    } arb_state_t;

endpackage

/* design/axi_rd_if.sv */
/*
 * AXI read channel bundle (AR and R) used between blocks of the subsystem.
 * The master side issues requests and accepts data, the slave side
 * accepts requests and returns data.
 */
`timescale 1ns/1ps

interface axi_rd_if import axi_rd_pkg::*;;

    // AR channel
    id_t   arid;
    addr_t araddr;
    len_t  arlen;
    logic  arvalid;
    logic  arready;

    // R channel
    id_t   rid;
    data_t rdata;
    logic  rlast;
    logic  rvalid;
    logic  rready;

    modport master (
        output arid, araddr, arlen, arvalid, rready,
        input  arready, rid, rdata, rlast, rvalid
    );

    modport slave (
        input  arid, araddr, arlen, arvalid, rready,
        output arready, rid, rdata, rlast, rvalid
    );

endinterface

/* design/axi_fifo_rd.sv */
/*
 * Read-data FIFO between one client and the shared read bus.
 * R beats are buffered with a registered read stage and an output register.
 * With FIFO_DELAY set, a client request is held until the buffer has room
 * for its whole burst, so a stalled client never blocks the shared memory.
 */
`timescale 1ns/1ps

module axi_fifo_rd import axi_rd_pkg::*; #(
    parameter int FIFO_DELAY = 1
) (
    input  logic     clk,
    input  logic     rst,
    axi_rd_if.slave  client,
    axi_rd_if.master downstream
);

    fifo_ptr_t wr_ptr_q;
    fifo_ptr_t rd_ptr_q;
    r_entry_t  buf_q [FIFO_DEPTH];
    r_entry_t  mem_rd_q;
    r_entry_t  out_q;
    logic      mem_rd_valid_q;
    logic      out_valid_q;
    logic      out_last;
    logic      full;
    logic      empty;
    logic      write;
    logic      read;
    logic      store_output;

    // Full when only the wrap bits differ
    assign full  = (wr_ptr_q[FIFO_AW] != rd_ptr_q[FIFO_AW]) &&
                   (wr_ptr_q[FIFO_AW-1:0] == rd_ptr_q[FIFO_AW-1:0]);
    assign empty = (wr_ptr_q == rd_ptr_q);

    assign downstream.rready = !full;
    assign write             = downstream.rvalid && !full;

    // Output register frees up when the client takes the beat or it is empty
    assign store_output = client.rready || !out_valid_q;
    assign read         = !empty && (store_output || !mem_rd_valid_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q       <= '0;
            rd_ptr_q       <= '0;
            mem_rd_valid_q <= 1'b0;
            out_valid_q    <= 1'b0;
        end else begin
            if (write) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (read) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (store_output || !mem_rd_valid_q) begin
                mem_rd_valid_q <= !empty;
            end
            if (store_output) begin
                out_valid_q <= mem_rd_valid_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            buf_q[wr_ptr_q[FIFO_AW-1:0]] <= {downstream.rid, downstream.rlast, downstream.rdata};
        end
        if (read) begin
            mem_rd_q <= buf_q[rd_ptr_q[FIFO_AW-1:0]];
        end
        if (store_output) begin
            out_q <= mem_rd_q;
        end
    end

    assign client.rvalid = out_valid_q;
    assign {client.rid, out_last, client.rdata} = out_q;

    // Stale output register must not show a last beat
    assign client.rlast = out_valid_q && out_last;

    generate
        if (FIFO_DELAY != 0) begin : g_delay
            fifo_ar_state_t state_q;
            fifo_ar_state_t state_d;
            fifo_cnt_t      count_q;
            fifo_cnt_t      count_d;
            id_t            ar_id_q;
            addr_t          ar_addr_q;
            len_t           ar_len_q;
            logic           ar_valid_q;
            logic           ar_valid_d;
            logic           ar_ready_q;
            logic           ar_ready_d;
            logic           client_take;
            logic           client_beat;
            logic           fits_new;
            logic           fits_held;

            assign client_take = client.arvalid && ar_ready_q;
            assign client_beat = client.rvalid && client.rready;

            // Count covers beats in flight and beats still buffered
            assign fits_new  = (count_q == '0) || (count_q + client.arlen + 1 <= FIFO_DEPTH);
            assign fits_held = (count_q == '0) || (count_q + ar_len_q + 1 <= FIFO_DEPTH);

            always_comb begin
                state_d    = state_q;
                count_d    = count_q;
                ar_valid_d = ar_valid_q && !downstream.arready;
                ar_ready_d = ar_ready_q;
                case (state_q)
                    AR_IDLE: begin
                        ar_ready_d = !downstream.arvalid || downstream.arready;
                        if (client_take) begin
                            ar_ready_d = 1'b0;
                            if (fits_new) begin
                                count_d    = count_q + client.arlen + 1'b1;
                                ar_valid_d = 1'b1;
                            end else begin
                                state_d = AR_WAIT;
                            end
                        end
                    end
                    AR_WAIT: begin
                        ar_ready_d = 1'b0;
                        if (fits_held) begin
                            count_d    = count_q + ar_len_q + 1'b1;
                            ar_valid_d = 1'b1;
                            state_d    = AR_IDLE;
                        end
                    end
                    default: state_d = AR_IDLE;
                endcase
                if (client_beat) begin
                    count_d = count_d - 1'b1;
                end
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    state_q    <= AR_IDLE;
                    count_q    <= '0;
                    ar_valid_q <= 1'b0;
                    ar_ready_q <= 1'b0;
                end else begin
                    state_q    <= state_d;
                    count_q    <= count_d;
                    ar_valid_q <= ar_valid_d;
                    ar_ready_q <= ar_ready_d;
                end
            end

            always_ff @(posedge clk) begin
                if (client_take) begin
                    ar_id_q   <= client.arid;
                    ar_addr_q <= client.araddr;
                    ar_len_q  <= client.arlen;
                end
            end

            assign downstream.arid    = ar_id_q;
            assign downstream.araddr  = ar_addr_q;
            assign downstream.arlen   = ar_len_q;
            assign downstream.arvalid = ar_valid_q;
            assign client.arready     = ar_ready_q;
        end else begin : g_bypass
            // Request goes out unchanged
            assign downstream.arid    = client.arid;
            assign downstream.araddr  = client.araddr;
            assign downstream.arlen   = client.arlen;
            assign downstream.arvalid = client.arvalid;
            assign client.arready     = downstream.arready;
        end
    endgenerate

endmodule

/* design/axi_rd_arbiter.sv */
/*
 * Round-robin read arbiter for NUM_PORTS clients onto one shared bus.
 * A grant is held for the whole burst and R beats return to that client.
 */
`timescale 1ns/1ps

module axi_rd_arbiter import axi_rd_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    axi_rd_if.slave  clients [NUM_PORTS],
    axi_rd_if.master shared
);

    arb_state_t state_q;
    port_t      grant_q;
    port_t      prio_q;
    port_t      sel;
    logic       any_req;
    logic       arvalid_v [NUM_PORTS];
    id_t        arid_v    [NUM_PORTS];
    addr_t      araddr_v  [NUM_PORTS];
    len_t       arlen_v   [NUM_PORTS];
    logic       rready_v  [NUM_PORTS];

    generate
        for (genvar i = 0; i < NUM_PORTS; i++) begin : g_client
            assign arvalid_v[i] = clients[i].arvalid;
            assign arid_v[i]    = clients[i].arid;
            assign araddr_v[i]  = clients[i].araddr;
            assign arlen_v[i]   = clients[i].arlen;
            assign rready_v[i]  = clients[i].rready;

            assign clients[i].arready = (state_q == ARB_IDLE) && any_req &&
                                        (sel == port_t'(i)) && shared.arready;

            // Data fields fan out, valid only to the granted client
            assign clients[i].rid    = shared.rid;
            assign clients[i].rdata  = shared.rdata;
            assign clients[i].rlast  = shared.rlast;
            assign clients[i].rvalid = (state_q == ARB_BURST) && (grant_q == port_t'(i)) &&
                                       shared.rvalid;
        end
    endgenerate

    // First requester at or after the priority pointer wins
    always_comb begin
        int idx;
        sel     = prio_q;
        any_req = 1'b0;
        for (int k = NUM_PORTS - 1; k >= 0; k--) begin
            idx = (int'(prio_q) + k) % NUM_PORTS;
            if (arvalid_v[idx]) begin
                sel     = port_t'(idx);
                any_req = 1'b1;
            end
        end
    end

    assign shared.arvalid = (state_q == ARB_IDLE) && any_req;
    assign shared.arid    = arid_v[sel];
    assign shared.araddr  = araddr_v[sel];
    assign shared.arlen   = arlen_v[sel];
    assign shared.rready  = (state_q == ARB_BURST) && rready_v[grant_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ARB_IDLE;
            grant_q <= '0;
            prio_q  <= '0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (shared.arvalid && shared.arready) begin
                        state_q <= ARB_BURST;
                        grant_q <= sel;
                        prio_q  <= port_t'((int'(sel) + 1) % NUM_PORTS);
                    end
                end
                ARB_BURST: begin
                    if (shared.rvalid && shared.rready && shared.rlast) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

endmodule

/* design/axi_rd_mem.sv */
/*
 * Word-wide on-chip memory serving incrementing read bursts.
 * One burst at a time; word index wraps at MEM_WORDS.
 * The load port writes one word per cycle for filling the contents.
 */
`timescale 1ns/1ps

module axi_rd_mem import axi_rd_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    load_en,
    input  addr_t   load_addr,
    input  data_t   load_data,
    axi_rd_if.slave port
);

    data_t    mem_q [MEM_WORDS];
    logic     busy_q;
    id_t      id_q;
    mem_idx_t idx_q;
    len_t     remain_q;
    data_t    rdata_q;
    mem_idx_t next_idx;
    logic     ar_take;
    logic     r_take;

    assign ar_take  = port.arvalid && !busy_q;
    assign r_take   = port.rvalid && port.rready;
    assign next_idx = idx_q + 1'b1;

    assign port.arready = !busy_q;
    assign port.rvalid  = busy_q;
    assign port.rid     = id_q;
    assign port.rdata   = rdata_q;
    assign port.rlast   = (remain_q == '0);

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem_q[load_addr[MEM_AW+1:2]] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else if (ar_take) begin
            busy_q <= 1'b1;
        end else if (r_take && port.rlast) begin
            busy_q <= 1'b0;
        end
    end

    // Beat register is refilled only when the current beat is taken
    always_ff @(posedge clk) begin
        if (ar_take) begin
            id_q     <= port.arid;
            idx_q    <= port.araddr[MEM_AW+1:2];
            remain_q <= port.arlen;
            rdata_q  <= mem_q[port.araddr[MEM_AW+1:2]];
        end else if (r_take && !port.rlast) begin
            idx_q    <= next_idx;
            remain_q <= remain_q - 1'b1;
            rdata_q  <= mem_q[next_idx];
        end
    end

endmodule

/* design/axi_rd_subsystem.sv */
/*
 * Top level of the shared read path: two client FIFOs, the arbiter and the
 * memory. Client channels and the memory load port are plain ports here.
 */
`timescale 1ns/1ps

module axi_rd_subsystem import axi_rd_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  load_en,
    input  addr_t load_addr,
    input  data_t load_data,

    // Client 0
    input  id_t   c0_arid,
    input  addr_t c0_araddr,
    input  len_t  c0_arlen,
    input  logic  c0_arvalid,
    output logic  c0_arready,
    output id_t   c0_rid,
    output data_t c0_rdata,
    output logic  c0_rlast,
    output logic  c0_rvalid,
    input  logic  c0_rready,

    // Client 1
    input  id_t   c1_arid,
    input  addr_t c1_araddr,
    input  len_t  c1_arlen,
    input  logic  c1_arvalid,
    output logic  c1_arready,
    output id_t   c1_rid,
    output data_t c1_rdata,
    output logic  c1_rlast,
    output logic  c1_rvalid,
    input  logic  c1_rready
);

    axi_rd_if client_bus [NUM_PORTS] ();
    axi_rd_if fifo_bus   [NUM_PORTS] ();
    axi_rd_if mem_bus ();

    assign client_bus[0].arid    = c0_arid;
    assign client_bus[0].araddr  = c0_araddr;
    assign client_bus[0].arlen   = c0_arlen;
    assign client_bus[0].arvalid = c0_arvalid;
    assign client_bus[0].rready  = c0_rready;
    assign c0_arready = client_bus[0].arready;
    assign c0_rid     = client_bus[0].rid;
    assign c0_rdata   = client_bus[0].rdata;
    assign c0_rlast   = client_bus[0].rlast;
    assign c0_rvalid  = client_bus[0].rvalid;

    assign client_bus[1].arid    = c1_arid;
    assign client_bus[1].araddr  = c1_araddr;
    assign client_bus[1].arlen   = c1_arlen;
    assign client_bus[1].arvalid = c1_arvalid;
    assign client_bus[1].rready  = c1_rready;
    assign c1_arready = client_bus[1].arready;
    assign c1_rid     = client_bus[1].rid;
    assign c1_rdata   = client_bus[1].rdata;
    assign c1_rlast   = client_bus[1].rlast;
    assign c1_rvalid  = client_bus[1].rvalid;

    generate
        for (genvar i = 0; i < NUM_PORTS; i++) begin : g_fifo
            axi_fifo_rd #(
                .FIFO_DELAY(1)
            ) fifo_inst (
                .clk        (clk),
                .rst        (rst),
                .client     (client_bus[i]),
                .downstream (fifo_bus[i])
            );
        end
    endgenerate

    axi_rd_arbiter arbiter_inst (
        .clk     (clk),
        .rst     (rst),
        .clients (fifo_bus),
        .shared  (mem_bus)
    );

    axi_rd_mem mem_inst (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .port      (mem_bus)
    );

endmodule

/* verification/axi_rd_subsystem_checker.sv */
/*
 * Handshake assertions on the client ports of the read subsystem.
 * Bound into axi_rd_subsystem by the testbench.
 */
`timescale 1ns/1ps

module axi_rd_subsystem_checker import axi_rd_pkg::*; (
    input logic  clk,
    input logic  rst,
    input id_t   c0_arid,
    input addr_t c0_araddr,
    input len_t  c0_arlen,
    input logic  c0_arvalid,
    input logic  c0_arready,
    input id_t   c0_rid,
    input data_t c0_rdata,
    input logic  c0_rlast,
    input logic  c0_rvalid,
    input logic  c0_rready,
    input id_t   c1_arid,
    input addr_t c1_araddr,
    input len_t  c1_arlen,
    input logic  c1_arvalid,
    input logic  c1_arready,
    input id_t   c1_rid,
    input data_t c1_rdata,
    input logic  c1_rlast,
    input logic  c1_rvalid,
    input logic  c1_rready
);

    int fail_count = 0;

    // Requests stay up with stable fields until accepted
    c0_ar_hold: assert property (@(posedge clk) disable iff (rst)
        c0_arvalid && !c0_arready |=> c0_arvalid && $stable({c0_arid, c0_araddr, c0_arlen}))
    else begin
        $error("client 0 request changed before arready");
        fail_count++;
    end

    c1_ar_hold: assert property (@(posedge clk) disable iff (rst)
        c1_arvalid && !c1_arready |=> c1_arvalid && $stable({c1_arid, c1_araddr, c1_arlen}))
    else begin
        $error("client 1 request changed before arready");
        fail_count++;
    end

    // Read beats stay up with stable fields until taken
    c0_r_hold: assert property (@(posedge clk) disable iff (rst)
        c0_rvalid && !c0_rready |=> c0_rvalid && $stable({c0_rid, c0_rdata, c0_rlast}))
    else begin
        $error("client 0 read beat changed before rready");
        fail_count++;
    end

    c1_r_hold: assert property (@(posedge clk) disable iff (rst)
        c1_rvalid && !c1_rready |=> c1_rvalid && $stable({c1_rid, c1_rdata, c1_rlast}))
    else begin
        $error("client 1 read beat changed before rready");
        fail_count++;
    end

    // Last flag only on a valid beat
    c0_last_valid: assert property (@(posedge clk) disable iff (rst)
        c0_rlast |-> c0_rvalid)
    else begin
        $error("client 0 rlast high without rvalid");
        fail_count++;
    end

    c1_last_valid: assert property (@(posedge clk) disable iff (rst)
        c1_rlast |-> c1_rvalid)
    else begin
        $error("client 1 rlast high without rvalid");
        fail_count++;
    end

    // No requests while in reset
    c0_ar_reset: assert property (@(posedge clk) rst |-> !c0_arvalid)
    else begin
        $error("client 0 arvalid high during reset");
        fail_count++;
    end

    c1_ar_reset: assert property (@(posedge clk) rst |-> !c1_arvalid)
    else begin
        $error("client 1 arvalid high during reset");
        fail_count++;
    end

endmodule

/* verification/axi_rd_subsystem_tb.sv */
/*
 * Directed testbench for the two-client AXI read subsystem.
 * Fills the memory through the load port, keeps a model of its contents
 * and checks every R beat of both clients against bursts built from it.
 */
`timescale 1ns/1ps

module axi_rd_subsystem_tb import axi_rd_pkg::*; ();

    localparam int NUM_BURSTS      = 48;
    localparam int BURST_CYCLES    = 200;
    localparam int WATCHDOG_CYCLES = NUM_BURSTS * BURST_CYCLES + MEM_WORDS + 16;
    localparam int AR_TIMEOUT      = 200;
    localparam int DRAIN_TIMEOUT   = 2000;
    localparam int RREADY_HIGH     = 0;
    localparam int RREADY_LOW      = 1;
    localparam int RREADY_RANDOM   = 2;

    typedef struct packed {
        id_t   id;
        logic  last;
        data_t data;
    } beat_t;

    logic  clk;
    logic  rst;
    logic  load_en;
    addr_t load_addr;
    data_t load_data;
    id_t   c0_arid;
    addr_t c0_araddr;
    len_t  c0_arlen;
    logic  c0_arvalid;
    logic  c0_arready;
    id_t   c0_rid;
    data_t c0_rdata;
    logic  c0_rlast;
    logic  c0_rvalid;
    logic  c0_rready;
    id_t   c1_arid;
    addr_t c1_araddr;
    len_t  c1_arlen;
    logic  c1_arvalid;
    logic  c1_arready;
    id_t   c1_rid;
    data_t c1_rdata;
    logic  c1_rlast;
    logic  c1_rvalid;
    logic  c1_rready;

    data_t model [MEM_WORDS];
    beat_t exp_q0 [$];
    beat_t exp_q1 [$];
    int    rready_mode [NUM_PORTS];
    int    error_count;
    string cur_test;

    axi_rd_subsystem axi_rd_subsystem_inst (.*);

    bind axi_rd_subsystem axi_rd_subsystem_checker checker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compare_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s data: expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_id(input string name, input id_t expected, input id_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s rid: expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_last(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s rlast: expected %b actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    function automatic int pending_beats(input int port);
        return (port == 0) ? exp_q0.size() : exp_q1.size();
    endfunction

    function automatic addr_t random_addr();
        return addr_t'($urandom & 32'h0000_FFFC);
    endfunction

    function automatic logic pick_rready(input int mode);
        case (mode)
            RREADY_LOW:    return 1'b0;
            RREADY_RANDOM: return 1'($urandom % 2);
            default:       return 1'b1;
        endcase
    endfunction

    task automatic check_beat(input int port, input id_t rid, input data_t rdata,
                              input logic rlast);
        beat_t want;
        string name;
        name = $sformatf("%s client %0d", cur_test, port);
        if (pending_beats(port) == 0) begin
            $display("Unexpected read beat on client %0d during %s", port, cur_test);
            error_count++;
        end else begin
            if (port == 0) begin
                want = exp_q0.pop_front();
            end else begin
                want = exp_q1.pop_front();
            end
            compare_data(name, want.data, rdata);
            compare_id(name, want.id, rid);
            compare_last(name, want.last, rlast);
        end
    endtask

    // Samples taken beats, then sets rready for the next cycle
    task automatic serve_r_channels();
        forever begin
            @(posedge clk);
            if (!rst && c0_rvalid && c0_rready) begin
                check_beat(0, c0_rid, c0_rdata, c0_rlast);
            end
            if (!rst && c1_rvalid && c1_rready) begin
                check_beat(1, c1_rid, c1_rdata, c1_rlast);
            end
            c0_rready <= pick_rready(rready_mode[0]);
            c1_rready <= pick_rready(rready_mode[1]);
        end
    endtask

    task automatic set_request(input int port, input logic valid, input id_t id,
                               input addr_t addr, input len_t len);
        if (port == 0) begin
            c0_arvalid <= valid;
            c0_arid    <= id;
            c0_araddr  <= addr;
            c0_arlen   <= len;
        end else begin
            c1_arvalid <= valid;
            c1_arid    <= id;
            c1_araddr  <= addr;
            c1_arlen   <= len;
        end
    endtask

    // Queues the expected beats, then holds the request until arready
    task automatic issue_read(input int port, input id_t id, input addr_t addr, input len_t len);
        beat_t beat;
        int    k;
        int    waited;
        logic  taken;
        for (k = 0; k <= int'(len); k++) begin
            beat.id   = id;
            beat.last = (k == int'(len));
            beat.data = model[(int'(addr) / 4 + k) % MEM_WORDS];
            if (port == 0) begin
                exp_q0.push_back(beat);
            end else begin
                exp_q1.push_back(beat);
            end
        end
        @(posedge clk);
        set_request(port, 1'b1, id, addr, len);
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < AR_TIMEOUT) begin
            @(posedge clk);
            waited++;
            taken = (port == 0) ? c0_arready : c1_arready;
        end
        set_request(port, 1'b0, id, addr, len);
        if (!taken) begin
            $display("Timeout in %s: client %0d request was never accepted", cur_test, port);
            error_count++;
        end
    endtask

    task automatic wait_drained(input int port);
        int waited;
        waited = 0;
        while (pending_beats(port) != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (pending_beats(port) != 0) begin
            $display("Timeout in %s: client %0d still waits for %0d beats",
                     cur_test, port, pending_beats(port));
            error_count++;
            if (port == 0) begin
                exp_q0.delete();
            end else begin
                exp_q1.delete();
            end
        end
    endtask

    task automatic load_memory();
        int    i;
        data_t word;
        for (i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            word     = $urandom;
            model[i] = word;
            load_en   <= 1'b1;
            load_addr <= addr_t'(i * 4);
            load_data <= word;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic single_reads();
        cur_test = "single_read";
        load_memory();
        issue_read(0, 4'h1, random_addr(), 8'd0);
        issue_read(1, 4'h2, random_addr(), 8'd0);
        wait_drained(0);
        wait_drained(1);
    endtask

    // Words 252 to 255, then wrap to 0
    task automatic burst_wrap();
        cur_test = "burst_wrap";
        issue_read(0, 4'h7, addr_t'(252 * 4), 8'd7);
        wait_drained(0);
    endtask

    task automatic simultaneous_clients();
        cur_test = "simultaneous";
        fork
            issue_read(0, 4'h3, random_addr(), 8'd15);
            issue_read(1, 4'hC, random_addr(), 8'd15);
        join
        wait_drained(0);
        wait_drained(1);
    endtask

    task automatic backpressure_hold();
        cur_test = "backpressure";
        rready_mode[0] = RREADY_LOW;
        issue_read(0, 4'h4, random_addr(), 8'd11);
        issue_read(0, 4'h5, random_addr(), 8'd11);
        issue_read(1, 4'h9, random_addr(), 8'd3);
        wait_drained(1);
        rready_mode[0] = RREADY_HIGH;
        wait_drained(0);
    endtask

    task automatic random_bursts(input int port);
        int n;
        for (n = 0; n < 20; n++) begin
            issue_read(port, id_t'($urandom), random_addr(), len_t'($urandom_range(15)));
        end
    endtask

    task automatic random_traffic();
        cur_test = "random_traffic";
        rready_mode[0] = RREADY_RANDOM;
        rready_mode[1] = RREADY_RANDOM;
        fork
            random_bursts(0);
            random_bursts(1);
        join
        wait_drained(0);
        wait_drained(1);
        rready_mode[0] = RREADY_HIGH;
        rready_mode[1] = RREADY_HIGH;
    endtask

    initial begin
        int assert_fails;
        void'($urandom(65714));
        error_count    = 0;
        cur_test       = "reset";
        rready_mode[0] = RREADY_HIGH;
        rready_mode[1] = RREADY_HIGH;
        rst        = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        c0_arid    = '0;
        c0_araddr  = '0;
        c0_arlen   = '0;
        c0_arvalid = 1'b0;
        c0_rready  = 1'b0;
        c1_arid    = '0;
        c1_araddr  = '0;
        c1_arlen   = '0;
        c1_arvalid = 1'b0;
        c1_rready  = 1'b0;
        fork
            serve_r_channels();
        join_none
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        single_reads();
        burst_wrap();
        simultaneous_clients();
        backpressure_hold();
        random_traffic();

        repeat (4) @(posedge clk);
        assert_fails = axi_rd_subsystem_inst.checker_inst.fail_count;
        $display("Checks done: %0d errors, %0d assertion failures", error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Bound covers every burst of the run plus the memory load
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles in %s, %0d errors so far",
                 WATCHDOG_CYCLES, cur_test, error_count);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* axi_rd_subsystem.f */
design/axi_rd_pkg.sv
design/axi_rd_if.sv
design/axi_fifo_rd.sv
design/axi_rd_arbiter.sv
design/axi_rd_mem.sv
design/axi_rd_subsystem.sv
verification/axi_rd_subsystem_checker.sv
verification/axi_rd_subsystem_tb.sv
